/* Makefile */
# Verilator build and run of the data cache testbench

VERILATOR ?= verilator
TOP       ?= dcache_tb
OBJ_DIR   ?= obj_dir
SIM       ?= $(OBJ_DIR)/V$(TOP)
VFLAGS    ?= --binary --timing --timescale 1ns/100ps -Wno-fatal
PASS_MSG  ?= TESTBENCH PASSED

SOURCES := $(filter %.sv %.v,$(shell cat list.f))

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): list.f $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f list.f

# Pass or fail comes from the pass line in the output
run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* list.f */
verilog/dcache_pkg.sv
verilog/cache_way.sv
verilog/way_select.sv
verilog/cache_ctrl.sv
verilog/dcache_top.sv
verif/tb_clock.sv
verif/dcache_tb.sv

/* verif/dcache_tb.sv */
`default_nettype none

module dcache_tb import dcache_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int max_vectors       = 64;
  localparam int line_words        = 1 << default_offset_w;
  localparam int cycles_per_vector = 200;

  logic     clk;
  logic     rst;
  logic     req;
  logic     wreq;
  word_t    addr;
  word_t    din;
  byte_en_t wbyte;
  logic     rdata_ok = 1'b0;
  logic     wdata_ok = 1'b0;
  word_t    sdata    = '0;
  word_t    rdata;
  logic     ok;
  logic     miss;
  logic     sen;
  logic     wen;
  word_t    raddr;
  word_t    waddr;
  word_t    wdata;

  word_t mem     [word_t]; // Words written back by the cache
  word_t ref_mem [word_t]; // Every CPU write applied at once
  word_t vec_mem [0:5*max_vectors-1];

  integer seed           = 34;
  int     n_vectors      = 0;
  logic   vectors_loaded = 1'b0;
  int     errors         = 0;
  int     checks         = 0;
  int     ok_count       = 0;
  int     sen_cycles     = 0;
  int     wb_words       = 0;
  int     rd_cnt         = 0;
  int     wb_cnt         = 0;
  word_t  last_waddr     = '0;

  tb_clock #(.period_ns(8)) clock_i (.clk(clk));

  dcache_top #(
    .ways     (default_ways),
    .index_w  (default_index_w),
    .offset_w (default_offset_w)
  ) dut_i (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .wreq     (wreq),
    .addr     (addr),
    .din      (din),
    .wbyte    (wbyte),
    .rdata_ok (rdata_ok),
    .wdata_ok (wdata_ok),
    .sdata    (sdata),
    .rdata    (rdata),
    .ok       (ok),
    .miss     (miss),
    .sen      (sen),
    .wen      (wen),
    .raddr    (raddr),
    .waddr    (waddr),
    .wdata    (wdata)
  );

  // Untouched memory holds its own byte address
  function automatic word_t mem_word(input word_t a);
    if (mem.exists(a))
      return mem[a];
    return a;
  endfunction

  function automatic word_t ref_word(input word_t a);
    if (ref_mem.exists(a))
      return ref_mem[a];
    return a;
  endfunction

  task automatic check_value(input string name, input word_t expected,
                             input word_t actual);
    checks++;
    if (actual !== expected)
    begin
      errors++;
      $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Memory model and bus monitor
  ////////////////////////////////////////////////////////////
  always @(posedge clk)
  begin : memory_model
    word_t wb_addr;

    if (ok)
      ok_count++;

    if (wen && wdata_ok)
    begin
      wb_addr = waddr + word_t'(4 * wb_cnt);
      check_value($sformatf("write-back to %h", wb_addr), ref_word(wb_addr), wdata);
      mem[wb_addr] = wdata;
      wb_cnt++;
      wb_words++;
      last_waddr = waddr;
    end
    if (!wen)
      wb_cnt = 0;

    if (sen)
    begin
      sen_cycles++;
      check_value("refill line base", addr & ~word_t'(4 * line_words - 1), raddr);
      if (rdata_ok)
        rd_cnt++;
    end
    else
      rd_cnt = 0;

    rdata_ok <= ($random(seed) % 4) != 0; // Stalls about one cycle in four
    wdata_ok <= ($random(seed) % 4) != 0;
    sdata    <= mem_word(raddr + word_t'(4 * (rd_cnt % line_words)));
  end

  // One vector request held until ok
  task automatic run_access(input int n);
    word_t    op;
    word_t    a;
    byte_en_t be;
    word_t    d;
    word_t    exp_word;
    word_t    merged;
    string    name;
    int       sen_before;
    int       wb_before;
    int       cycles;

    op       = vec_mem[5 * n];
    a        = vec_mem[5 * n + 1];
    be       = byte_en_t'(vec_mem[5 * n + 2]);
    d        = vec_mem[5 * n + 3];
    exp_word = vec_mem[5 * n + 4];
    name     = $sformatf("vector %0d at %h", n, a);

    @(posedge clk);
    req   <= 1'b1;
    wreq  <= (op == 1);
    addr  <= a;
    din   <= d;
    wbyte <= be;
    sen_before = sen_cycles;
    wb_before  = wb_words;
    cycles     = 0;
    do
    begin
      @(posedge clk);
      cycles++;
      // Low in idle and both lookups, high through the memory bursts
      check_value({name, " miss flag"}, word_t'(cycles > 2 && !ok), word_t'(miss));
    end
    while (!ok);
    req  <= 1'b0;
    wreq <= 1'b0;

    if (op == 1)
    begin
      merged = ref_word(a);
      for (int b = 0; b < 4; b++)
      begin
        if (be[b])
          merged[8*b +: 8] = d[8*b +: 8];
      end
      ref_mem[a] = merged;
    end
    else
      check_value(name, exp_word, rdata);

    if (op == 2)
      check_value({name, " refill cycles"}, '0, word_t'(sen_cycles - sen_before));
    if (op == 3)
    begin
      check_value({name, " write-back address"}, d, last_waddr);
      check_value({name, " write-back words"}, word_t'(line_words),
                  word_t'(wb_words - wb_before));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////
  initial
  begin
    rst   = 1'b1;
    req   = 1'b0;
    wreq  = 1'b0;
    addr  = '0;
    din   = '0;
    wbyte = '0;
    for (int i = 0; i < 5 * max_vectors; i++)
      vec_mem[i] = '1;
    $readmemh("verif/dcache_vectors.txt", vec_mem);
    while (n_vectors < max_vectors && vec_mem[5 * n_vectors] !== '1)
      n_vectors++;
    vectors_loaded = 1'b1;

    for (int c = 0; c < 16; c++)
    begin
      @(posedge clk);
      if (c > 0)
        check_value("outputs in reset", '0, word_t'({ok, sen, wen, miss}));
    end
    rst <= 1'b0;
    repeat (4)
    begin
      @(posedge clk);
      check_value("outputs before first request", '0, word_t'({ok, sen, wen, miss}));
    end

    if (n_vectors == 0)
    begin
      errors++;
      $display("No vectors were read from verif/dcache_vectors.txt");
    end
    for (int n = 0; n < n_vectors; n++)
      run_access(n);
    repeat (4) @(posedge clk);

    check_value("ok pulse count", word_t'(n_vectors), word_t'(ok_count));
    $display("Finished %0d vectors, %0d checks, %0d errors", n_vectors, checks, errors);
    if (errors == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

  initial
  begin : watchdog
    wait (vectors_loaded);
    repeat (40 + cycles_per_vector * n_vectors) @(posedge clk);
    $display("Timeout: the vectors did not finish within %0d cycles",
             40 + cycles_per_vector * n_vectors);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* verif/dcache_vectors.txt */
// op addr byte_en wdata expected, all hex
// op 0 read, 1 write, 2 read that must hit, 3 read that writes back the line in wdata
0 00000104 0 00000000 00000104
2 00000104 0 00000000 00000104
1 00000108 a aabbccdd 00000000
2 00000108 0 00000000 aa00cc08
2 0000013c 0 00000000 0000013c
1 00000204 3 12345678 00000000 // Write miss allocates
2 00000204 0 00000000 00005678
// Six lines in set 2
0 00001080 0 00000000 00001080
1 00001080 f a0a0a0a0 00000000
0 00001480 0 00000000 00001480
1 00001480 f b0b0b0b0 00000000
0 00001880 0 00000000 00001880
1 00001880 1 000000c5 00000000
0 00001c80 0 00000000 00001c80
1 00001c80 c d0d00000 00000000
3 00002080 0 00001080 00002080
1 00002080 f e0e0e0e0 00000000
3 00002480 0 00001480 00002480
3 00001080 0 00001880 a0a0a0a0
3 00001480 0 00001c80 b0b0b0b0
2 00001084 0 00000000 00001084
3 00001880 0 00002080 000018c5
0 00001c80 0 00000000 d0d01c80 // Clean victim
0 000020a0 0 00000000 000020a0
0 00003ffc 0 00000000 00003ffc
1 00003ff0 4 00770000 00000000
2 00003ff0 0 00000000 00773ff0

/* verif/tb_clock.sv */
`default_nettype none

module tb_clock
#(
  parameter int period_ns = 8
)
(
  output logic clk
);
  timeunit 1ns;
  timeprecision 100ps;

  initial
  begin
    clk = 1'b0;
    forever
      #(period_ns / 2) clk = ~clk;
  end

endmodule

`default_nettype wire

/* verilog/cache_ctrl.sv */
`default_nettype none

module cache_ctrl import dcache_pkg::*;
#(
  parameter int ways     = default_ways,
  parameter int index_w  = default_index_w,
  parameter int offset_w = default_offset_w
)
(
  input  wire                                           clk,
  input  wire                                           rst,
  // CPU side
  input  wire                                           req,
  input  wire                                           wreq,
  input  wire  word_t                                   addr,
  input  wire  word_t                                   din,
  input  wire  byte_en_t                                wbyte,
  output logic                                          ok,
  output logic                                          miss,
  output word_t                                         rdata,
  // Memory side
  input  wire                                           rdata_ok,
  input  wire                                           wdata_ok,
  input  wire  word_t                                   sdata,
  output logic                                          sen,
  output logic                                          wen,
  output word_t                                         raddr,
  output word_t                                         waddr,
  output word_t                                         wdata,
  // From the way selector
  input  wire                                           hit,
  input  wire  [((ways > 1) ? $clog2(ways) : 1)-1:0]    hit_way,
  input  wire  [((ways > 1) ? $clog2(ways) : 1)-1:0]    victim_way,
  input  wire                                           victim_dirty,
  input  wire  [addr_w-index_w-offset_w-3:0]            victim_tag,
  input  wire  word_t [(1 << offset_w)-1:0]             victim_line,
  input  wire  word_t                                   read_word,
  // To the ways
  output logic [index_w-1:0]                            index,
  output logic [offset_w-1:0]                           offset,
  output word_t                                         wr_data,
  output byte_en_t                                      wr_bytes,
  output logic [ways-1:0]                               wr_en,
  output logic [ways-1:0]                               fill_en,
  output word_t                                         fill_word,
  output logic [addr_w-index_w-offset_w-3:0]            tag_in,
  output logic [ways-1:0]                               tag_load,
  output logic [ways-1:0]                               access_en,
  output logic [((ways > 1) ? $clog2(ways) : 1)-1:0]    access_way
);

  localparam int tag_w = addr_w - index_w - offset_w - 2;
  localparam int words = 1 << offset_w;
  localparam int way_w = (ways > 1) ? $clog2(ways) : 1;

  ctrl_state_t state;
  ctrl_state_t next_state;

  word_t                addr_q;
  logic [offset_w-1:0]  word_cnt;
  logic                 last_word;
  logic                 wb_beat;
  logic                 fill_beat;

  logic [way_w-1:0]     victim_way_q;
  logic [tag_w-1:0]     victim_tag_q;
  word_t [words-1:0]    victim_line_q;

  ////////////////////////////////////////////////////////////
  // Request state machine
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      state <= idle;
    else
      state <= next_state;
  end

  always_comb
  begin
    next_state = state;
    case (state)
      idle:
        if (req)
          next_state = lookup;
      lookup:
        if (hit)
          next_state = idle;
        else if (victim_dirty)
          next_state = write_back;
        else
          next_state = refill;
      write_back:
        if (wb_beat && last_word)
          next_state = refill;
      refill:
        if (fill_beat && last_word)
          next_state = lookup; // Second lookup hits
      default:
        next_state = idle;
    endcase
  end

  assign last_word = (word_cnt == {offset_w{1'b1}});
  assign wb_beat   = wen && wdata_ok;
  assign fill_beat = sen && rdata_ok;

  // One counter serves both bursts; they never overlap
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      word_cnt <= '0;
    else if (state == lookup)
      word_cnt <= '0;
    else if (wb_beat || fill_beat)
      word_cnt <= word_cnt + 1'b1;
  end

  ////////////////////////////////////////////////////////////
  // Request address and victim copy
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk)
  begin
    if (state == idle && req)
      addr_q <= addr;
    if (state == lookup && !hit)
    begin
      victim_way_q  <= victim_way;
      victim_tag_q  <= victim_tag;
      victim_line_q <= victim_line; // Stable source for write-back
    end
  end

  assign index  = addr_q[offset_w+2 +: index_w];
  assign offset = (state == refill) ? word_cnt : addr_q[2 +: offset_w];
  assign tag_in = addr_q[addr_w-1 -: tag_w];

  assign wr_data   = din;
  assign wr_bytes  = wbyte;
  assign fill_word = sdata;

  // Per-way strobes
  always_comb
  begin
    wr_en    = '0;
    fill_en  = '0;
    tag_load = '0;
    if (ok && wreq)
      wr_en[hit_way] = 1'b1;
    if (fill_beat)
    begin
      fill_en[victim_way_q] = 1'b1;
      if (last_word)
        tag_load[victim_way_q] = 1'b1; // Line now valid and clean
    end
  end

  assign ok         = (state == lookup) && hit;
  assign access_en  = {ways{ok}};
  assign access_way = hit_way;
  assign rdata      = read_word;

  ////////////////////////////////////////////////////////////
  // Memory channels
  ////////////////////////////////////////////////////////////
  assign sen   = (state == refill);
  assign wen   = (state == write_back);
  assign miss  = sen || wen;
  assign raddr = {addr_q[addr_w-1:offset_w+2], {(offset_w + 2){1'b0}}};
  assign waddr = {victim_tag_q, index, {(offset_w + 2){1'b0}}};
  assign wdata = victim_line_q[word_cnt];

endmodule

`default_nettype wire

/* verilog/cache_way.sv */
`default_nettype none

module cache_way import dcache_pkg::*;
#(
  parameter int ways     = default_ways,
  parameter int index_w  = default_index_w,
  parameter int offset_w = default_offset_w,
  parameter int way_id   = 0
)
(
  input  wire                                           clk,
  input  wire                                           rst,
  input  wire  [index_w-1:0]                            index,
  input  wire  [offset_w-1:0]                           offset,
  input  wire  word_t                                   wr_data,
  input  wire  byte_en_t                                wr_bytes,
  input  wire                                           wr_en,
  input  wire  word_t                                   fill_word,
  input  wire                                           fill_en,
  input  wire  [addr_w-index_w-offset_w-3:0]            tag_in,
  input  wire                                           tag_load,
  input  wire                                           access_en,
  input  wire  [((ways > 1) ? $clog2(ways) : 1)-1:0]    access_way,
  input  wire  [addr_w-index_w-offset_w-3:0]            lookup_tag,
  output logic                                          match,
  output logic                                          valid,
  output logic                                          dirty,
  output age_t                                          age,
  output logic [addr_w-index_w-offset_w-3:0]            stored_tag,
  output word_t                                         word_out,
  output word_t [(1 << offset_w)-1:0]                   line_out
);

  localparam int tag_w = addr_w - index_w - offset_w - 2;
  localparam int sets  = 1 << index_w;
  localparam int words = 1 << offset_w;
  localparam int way_w = (ways > 1) ? $clog2(ways) : 1;

  word_t [words-1:0] data_q [sets];
  logic [tag_w-1:0]  tag_q  [sets];
  age_t              age_q  [sets];
  logic [sets-1:0]   valid_q;
  logic [sets-1:0]   dirty_q;

  ////////////////////////////////////////////////////////////
  // Line data and tags
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk)
  begin
    if (fill_en)
      data_q[index][offset] <= fill_word;
    else if (wr_en)
    begin
      for (int b = 0; b < 4; b++)
      begin
        if (wr_bytes[b])
          data_q[index][offset][8*b +: 8] <= wr_data[8*b +: 8]; // Byte merge
      end
    end
    if (tag_load)
      tag_q[index] <= tag_in;
  end

  ////////////////////////////////////////////////////////////
  // Valid, dirty and replacement age
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      valid_q <= '0;
      dirty_q <= '0;
      for (int s = 0; s < sets; s++)
        age_q[s] <= '0;
    end
    else
    begin
      if (tag_load)
      begin
        valid_q[index] <= 1'b1;
        dirty_q[index] <= 1'b0; // Fresh line is clean
      end
      else if (wr_en)
        dirty_q[index] <= 1'b1;

      if (access_en)
      begin
        if (access_way == way_w'(way_id))
          age_q[index] <= '0;
        else if (age_q[index] != 2'd3)
          age_q[index] <= age_q[index] + 2'd1;
      end
    end
  end

  assign stored_tag = tag_q[index];
  assign match      = (tag_q[index] == lookup_tag);
  assign valid      = valid_q[index];
  assign dirty      = dirty_q[index];
  assign age        = age_q[index];
  assign word_out   = data_q[index][offset];
  assign line_out   = data_q[index];

endmodule

`default_nettype wire

/* verilog/dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

  ////////////////////////////////////////////////////////////
  // Geometry defaults passed down from the top level
  ////////////////////////////////////////////////////////////
  parameter int addr_w           = 32;
  parameter int default_ways     = 4;
  parameter int default_index_w  = 4; // 16 sets
  parameter int default_offset_w = 4; // 16 words per line

  typedef logic [31:0] word_t;

  // Bit 3 selects the top byte
  typedef logic [3:0] byte_en_t;

  // Saturates at 3
  typedef logic [1:0] age_t;

  typedef enum logic [1:0] {
    idle       = 2'd0,
    lookup     = 2'd1,
    write_back = 2'd2,
    refill     = 2'd3
  } ctrl_state_t;

endpackage

`default_nettype wire

/* verilog/dcache_top.sv */
`default_nettype none

module dcache_top import dcache_pkg::*;
#(
  parameter int ways     = default_ways,
  parameter int index_w  = default_index_w,
  parameter int offset_w = default_offset_w
)
(
  input  wire         clk,
  input  wire         rst,
  input  wire         req,
  input  wire         wreq,
  input  wire  word_t addr,
  input  wire  word_t din,
  input  wire  byte_en_t wbyte,
  input  wire         rdata_ok,
  input  wire         wdata_ok,
  input  wire  word_t sdata,
  output word_t       rdata,
  output logic        ok,
  output logic        miss,
  output logic        sen,
  output logic        wen,
  output word_t       raddr,
  output word_t       waddr,
  output word_t       wdata
);

  localparam int tag_w = addr_w - index_w - offset_w - 2;
  localparam int words = 1 << offset_w;
  localparam int way_w = (ways > 1) ? $clog2(ways) : 1;

  // Controller to ways
  logic [index_w-1:0]  index;
  logic [offset_w-1:0] offset;
  word_t               wr_data;
  byte_en_t            wr_bytes;
  logic [ways-1:0]     wr_en;
  logic [ways-1:0]     fill_en;
  word_t               fill_word;
  logic [tag_w-1:0]    tag_in;
  logic [ways-1:0]     tag_load;
  logic [ways-1:0]     access_en;
  logic [way_w-1:0]    access_way;

  // Ways to selector
  logic [ways-1:0]              match;
  logic [ways-1:0]              valid;
  logic [ways-1:0]              dirty;
  age_t [ways-1:0]              age;
  logic [ways-1:0][tag_w-1:0]   stored_tag;
  word_t [ways-1:0]             word_out;
  word_t [ways-1:0][words-1:0]  line_out;

  // Selector to controller
  logic              hit;
  logic [way_w-1:0]  hit_way;
  logic [way_w-1:0]  victim_way;
  logic              victim_dirty;
  logic [tag_w-1:0]  victim_tag;
  word_t [words-1:0] victim_line;
  word_t             read_word;

  cache_ctrl #(
    .ways     (ways),
    .index_w  (index_w),
    .offset_w (offset_w)
  ) ctrl_i (
    .clk          (clk),
    .rst          (rst),
    .req          (req),
    .wreq         (wreq),
    .addr         (addr),
    .din          (din),
    .wbyte        (wbyte),
    .ok           (ok),
    .miss         (miss),
    .rdata        (rdata),
    .rdata_ok     (rdata_ok),
    .wdata_ok     (wdata_ok),
    .sdata        (sdata),
    .sen          (sen),
    .wen          (wen),
    .raddr        (raddr),
    .waddr        (waddr),
    .wdata        (wdata),
    .hit          (hit),
    .hit_way      (hit_way),
    .victim_way   (victim_way),
    .victim_dirty (victim_dirty),
    .victim_tag   (victim_tag),
    .victim_line  (victim_line),
    .read_word    (read_word),
    .index        (index),
    .offset       (offset),
    .wr_data      (wr_data),
    .wr_bytes     (wr_bytes),
    .wr_en        (wr_en),
    .fill_en      (fill_en),
    .fill_word    (fill_word),
    .tag_in       (tag_in),
    .tag_load     (tag_load),
    .access_en    (access_en),
    .access_way   (access_way)
  );

  for (genvar g = 0; g < ways; g++)
  begin : g_way
    cache_way #(
      .ways     (ways),
      .index_w  (index_w),
      .offset_w (offset_w),
      .way_id   (g)
    ) way_i (
      .clk        (clk),
      .rst        (rst),
      .index      (index),
      .offset     (offset),
      .wr_data    (wr_data),
      .wr_bytes   (wr_bytes),
      .wr_en      (wr_en[g]),
      .fill_word  (fill_word),
      .fill_en    (fill_en[g]),
      .tag_in     (tag_in),
      .tag_load   (tag_load[g]),
      .access_en  (access_en[g]),
      .access_way (access_way),
      .lookup_tag (tag_in), // Request tag doubles as the compare tag
      .match      (match[g]),
      .valid      (valid[g]),
      .dirty      (dirty[g]),
      .age        (age[g]),
      .stored_tag (stored_tag[g]),
      .word_out   (word_out[g]),
      .line_out   (line_out[g])
    );
  end

  way_select #(
    .ways     (ways),
    .index_w  (index_w),
    .offset_w (offset_w)
  ) select_i (
    .match        (match),
    .valid        (valid),
    .dirty        (dirty),
    .age          (age),
    .stored_tag   (stored_tag),
    .word_out     (word_out),
    .line_out     (line_out),
    .hit          (hit),
    .hit_way      (hit_way),
    .victim_way   (victim_way),
    .victim_dirty (victim_dirty),
    .victim_tag   (victim_tag),
    .victim_line  (victim_line),
    .read_word    (read_word)
  );

endmodule

`default_nettype wire

/* verilog/way_select.sv */
`default_nettype none

module way_select import dcache_pkg::*;
#(
  parameter int ways     = default_ways,
  parameter int index_w  = default_index_w,
  parameter int offset_w = default_offset_w
)
(
  input  wire  [ways-1:0]                                       match,
  input  wire  [ways-1:0]                                       valid,
  input  wire  [ways-1:0]                                       dirty,
  input  wire  age_t [ways-1:0]                                 age,
  input  wire  [ways-1:0][addr_w-index_w-offset_w-3:0]          stored_tag,
  input  wire  word_t [ways-1:0]                                word_out,
  input  wire  word_t [ways-1:0][(1 << offset_w)-1:0]           line_out,
  output logic                                                  hit,
  output logic [((ways > 1) ? $clog2(ways) : 1)-1:0]            hit_way,
  output logic [((ways > 1) ? $clog2(ways) : 1)-1:0]            victim_way,
  output logic                                                  victim_dirty,
  output logic [addr_w-index_w-offset_w-3:0]                    victim_tag,
  output word_t [(1 << offset_w)-1:0]                           victim_line,
  output word_t                                                 read_word
);

  localparam int way_w = (ways > 1) ? $clog2(ways) : 1;

  logic all_valid;

  // Lowest matching way wins
  always_comb
  begin
    hit     = 1'b0;
    hit_way = '0;
    for (int i = ways - 1; i >= 0; i--)
    begin
      if (match[i] && valid[i])
      begin
        hit     = 1'b1;
        hit_way = way_w'(i);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Replacement victim
  ////////////////////////////////////////////////////////////
  always_comb
  begin
    all_valid  = &valid;
    victim_way = '0;
    if (!all_valid)
    begin
      for (int i = ways - 1; i >= 0; i--)
      begin
        if (!valid[i])
          victim_way = way_w'(i); // Fill empty ways first
      end
    end
    else
    begin
      for (int i = 1; i < ways; i++)
      begin
        if (age[i] > age[victim_way])
          victim_way = way_w'(i); // Strict compare keeps lowest on tie
      end
    end
  end

  assign victim_dirty = dirty[victim_way] && valid[victim_way];
  assign victim_tag   = stored_tag[victim_way];
  assign victim_line  = line_out[victim_way];
  assign read_word    = word_out[hit_way];

endmodule

`default_nettype wire
